/* rtl/core_pkg.sv */
// Shared widths, memory map and encodings of the single-cycle RV32I core
// Every RTL unit takes what it needs by a wildcard import
package core_pkg;

    ////////////////////////////////////////
    // ISA widths
    ////////////////////////////////////////
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;    // Data or address word
    typedef logic [4:0]      gpr_addr_t; // x0..x31

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////
    localparam int    ROM_ADDR_WIDTH = 10;            // Word index, 4 kB
    localparam int    RAM_ADDR_WIDTH = 10;            // Word index, 4 kB
    localparam word_t ROM_BASE_ADDR  = 32'h0000_0000;
    localparam word_t RAM_BASE_ADDR  = 32'h0001_0000; // Aligned to RAM size
    localparam word_t RESET_ADDR     = ROM_BASE_ADDR; // Boot from start of ROM

    // Instruction field positions, LSB of each field
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    // Major opcodes still decoded, everything else is a no-op
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_t;

    // funct3 of OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // SRL or SRA by funct7
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 of BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    ////////////////////////////////////////
    // Unit operations
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU,
        PASS_B              // Result is src2, for LUI and link address
    } alu_op_t;

    typedef enum logic [1:0] {
        LSU_NONE  = 2'd0,   // No write-back
        LSU_ALU   = 2'd1,   // Write back ALU result
        LSU_LOAD  = 2'd2,   // Write back RAM word
        LSU_STORE = 2'd3    // Write RAM only
    } lsu_op_t;

    localparam word_t NOP_INST = 32'h0000_0013; // ADDI x0,x0,0

endpackage

/* rtl/fetch.sv */
// Instruction fetch: program counter and instruction ROM read port
// PC loads next_pc on every edge, ROM answers in the same cycle
`timescale 1ns/1ps

module fetch (
    input  logic                                 clk,
    input  logic                                 rst,
    input  core_pkg::word_t                      next_pc,     // From decoder
    output core_pkg::word_t                      pc,
    output core_pkg::word_t                      inst,
    output logic                                 rom_rd_en,
    output logic [core_pkg::ROM_ADDR_WIDTH-1:0]  rom_addr,    // Word index
    input  core_pkg::word_t                      rom_rd_data
);
    import core_pkg::*;

    word_t rom_offset; // Byte offset into the ROM

    ////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_ADDR;
        end else begin
            pc <= next_pc; // One instruction per clock
        end
    end

    ////////////////////////////////////////
    // ROM read port
    ////////////////////////////////////////
    assign rom_offset = pc - ROM_BASE_ADDR;
    assign rom_addr   = rom_offset[ROM_ADDR_WIDTH+1:2]; // Drop byte bits
    assign rom_rd_en  = !rst;

    // Hold a NOP in reset so nothing reaches the RAM or regfile
    assign inst = rst ? NOP_INST : rom_rd_data;

endmodule

/* rtl/regfile.sv */
// General purpose registers, two combinational reads and one write
// x0 reads as zero, writes land at the rising edge
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  core_pkg::gpr_addr_t rs1_addr,
    input  core_pkg::gpr_addr_t rs2_addr,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    input  logic                dest_en,
    input  core_pkg::gpr_addr_t dest_addr,
    input  core_pkg::word_t     dest_data
);
    import core_pkg::*;

    word_t regs [1:31]; // x1..x31, no storage for x0

    // Write port
    always_ff @(posedge clk) begin
        if (dest_en && (dest_addr != '0)) begin
            regs[dest_addr] <= dest_data;
        end
    end

    // Read ports, old value on same-cycle write
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    always_comb begin
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

/* rtl/decoder.sv */
// Instruction decode for the single-cycle core
// Builds immediates, picks ALU operands and op, resolves branches and next PC
`timescale 1ns/1ps

module decoder (
    input  core_pkg::word_t     inst,
    input  core_pkg::word_t     pc,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    input  logic                alu_zero,   // Compare outcome for branches
    output core_pkg::gpr_addr_t rs1_addr,
    output core_pkg::gpr_addr_t rs2_addr,
    output core_pkg::word_t     src1,
    output core_pkg::word_t     src2,
    output core_pkg::alu_op_t   alu_op,
    output core_pkg::lsu_op_t   lsu_op,
    output core_pkg::gpr_addr_t dest_addr,
    output core_pkg::word_t     alt_data,   // Store data or link address
    output core_pkg::word_t     next_pc
);
    import core_pkg::*;

    // Maps funct3 of OP and OP_IMM onto an ALU operation
    function automatic alu_op_t arith_op(logic [2:0] f3, logic alt, logic reg_reg);
        alu_op_t op;
        case (f3)
            F3_ADD_SUB: op = (alt && reg_reg) ? SUB : ADD; // No SUBI
            F3_SLL:     op = SLL;
            F3_SLT:     op = SLT;
            F3_SLTU:    op = SLTU;
            F3_XOR:     op = XOR;
            F3_SR:      op = alt ? SRA : SRL;
            F3_OR:      op = OR;
            F3_AND:     op = AND;
            default:    op = ADD;
        endcase
        return op;
    endfunction

    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    word_t       imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t       pc_plus4;
    word_t       branch_target;
    word_t       jal_target;
    word_t       jalr_target;
    logic        branch_taken;

    ////////////////////////////////////////
    // Fields and immediates
    ////////////////////////////////////////
    assign opcode    = opcode_t'(inst[OPCODE_LSB +: 7]);
    assign funct3    = inst[FUNCT3_LSB +: 3];
    assign funct7    = inst[FUNCT7_LSB +: 7];
    assign rs1_addr  = inst[RS1_LSB +: 5];
    assign rs2_addr  = inst[RS2_LSB +: 5];
    assign dest_addr = inst[RD_LSB +: 5];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // Target adders, separate from the ALU
    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc + imm_b;
    assign jal_target    = pc + imm_j;
    assign jalr_target   = (rs1_data + imm_i) & ~32'd1; // Clear bit 0

    // Taken test from the compare the ALU did this cycle
    always_comb begin
        case (funct3)
            F3_BEQ:  branch_taken = alu_zero;   // SUB is zero
            F3_BNE:  branch_taken = !alu_zero;
            F3_BLT:  branch_taken = !alu_zero;  // SLT gave 1
            F3_BGE:  branch_taken = alu_zero;
            F3_BLTU: branch_taken = !alu_zero;
            F3_BGEU: branch_taken = alu_zero;
            default: branch_taken = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Operand, operation and next PC
    ////////////////////////////////////////
    always_comb begin
        src1     = rs1_data;
        src2     = rs2_data;
        alu_op   = ADD;
        lsu_op   = LSU_NONE; // Unknown opcodes fall through as no-ops
        alt_data = rs2_data;
        next_pc  = pc_plus4;
        case (opcode)
            OP: begin
                alu_op = arith_op(funct3, funct7[5], 1'b1);
                lsu_op = LSU_ALU;
            end
            OP_IMM: begin
                src2   = imm_i;
                alu_op = arith_op(funct3, funct7[5], 1'b0); // SRAI keeps bit 30
                lsu_op = LSU_ALU;
            end
            LUI: begin
                src2   = imm_u;
                alu_op = PASS_B;
                lsu_op = LSU_ALU;
            end
            AUIPC: begin
                src1   = pc;
                src2   = imm_u;
                lsu_op = LSU_ALU;
            end
            BRANCH: begin
                case (funct3)
                    F3_BEQ, F3_BNE:   alu_op = SUB;
                    F3_BLT, F3_BGE:   alu_op = SLT;
                    F3_BLTU, F3_BGEU: alu_op = SLTU;
                    default:          alu_op = ADD;
                endcase
                if (branch_taken) begin
                    next_pc = branch_target;
                end
            end
            JAL, JALR: begin
                src2     = pc_plus4;    // Link address through the ALU
                alu_op   = PASS_B;
                lsu_op   = LSU_ALU;
                alt_data = pc_plus4;
                next_pc  = (opcode == JAL) ? jal_target : jalr_target;
            end
            LOAD: begin
                src2   = imm_i;         // Address is rs1 + offset
                lsu_op = LSU_LOAD;
            end
            STORE: begin
                src2   = imm_s;
                lsu_op = LSU_STORE;
            end
            default: begin
            end
        endcase
    end

endmodule

/* rtl/alu.sv */
// Combinational ALU: add/sub, logic, shifts and compares
// zero flags an all-zero result, used by the decoder to resolve branches
`timescale 1ns/1ps

module alu (
    input  core_pkg::word_t   src1,
    input  core_pkg::word_t   src2,
    input  core_pkg::alu_op_t alu_op,
    output core_pkg::word_t   result,
    output logic              zero
);
    import core_pkg::*;

    logic [4:0] shamt;   // Low five bits of src2
    logic       lt_s;
    logic       lt_u;

    assign shamt = src2[4:0];
    assign lt_s  = $signed(src1) < $signed(src2);
    assign lt_u  = src1 < src2;

    always_comb begin
        case (alu_op)
            ADD:     result = src1 + src2;
            SUB:     result = src1 - src2;
            AND:     result = src1 & src2;
            OR:      result = src1 | src2;
            XOR:     result = src1 ^ src2;
            SLL:     result = src1 << shamt;
            SRL:     result = src1 >> shamt;
            SRA:     result = word_t'($signed(src1) >>> shamt); // Sign fill
            SLT:     result = {{(XLEN-1){1'b0}}, lt_s};
            SLTU:    result = {{(XLEN-1){1'b0}}, lt_u};
            PASS_B:  result = src2;
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* rtl/lsu.sv */
// Load/store unit: RAM window decode, word strobes and write-back select
// Purely combinational, the RAM and regfile write at the clock edge
`timescale 1ns/1ps

module lsu (
    input  core_pkg::lsu_op_t                    lsu_op,
    input  core_pkg::word_t                      alu_result, // Byte address
    input  core_pkg::word_t                      alt_data,   // Store data
    input  core_pkg::gpr_addr_t                  dest_addr,
    input  core_pkg::word_t                      ram_rd_data,
    output logic                                 dest_en,
    output core_pkg::word_t                      dest_data,
    output logic                                 ram_rd_en,
    output logic                                 ram_wr_en,
    output logic [core_pkg::RAM_ADDR_WIDTH-1:0]  ram_addr,
    output core_pkg::word_t                      wr_data
);
    import core_pkg::*;

    localparam int WIN_LSB = RAM_ADDR_WIDTH + 2; // First bit above the window

    logic  in_ram;
    word_t load_data;

    ////////////////////////////////////////
    // RAM window
    ////////////////////////////////////////
    // Base is size-aligned, so compare the upper bits only
    assign in_ram = (alu_result[XLEN-1:WIN_LSB] == RAM_BASE_ADDR[XLEN-1:WIN_LSB]);

    assign ram_addr  = alu_result[WIN_LSB-1:2]; // Word index
    assign ram_rd_en = (lsu_op == LSU_LOAD) && in_ram;
    assign ram_wr_en = (lsu_op == LSU_STORE) && in_ram;
    assign wr_data   = alt_data;

    // Outside the window a load returns zero
    assign load_data = in_ram ? ram_rd_data : '0;

    ////////////////////////////////////////
    // Write-back
    ////////////////////////////////////////
    always_comb begin
        case (lsu_op)
            LSU_LOAD: dest_data = load_data;
            default:  dest_data = alu_result; // Link address already via ALU
        endcase
    end

    // x0 never written
    assign dest_en = ((lsu_op == LSU_ALU) || (lsu_op == LSU_LOAD)) && (dest_addr != '0);

endmodule

/* rtl/core.sv */
// Top level of the single-cycle RV32I core
// Connects fetch, decode, regfile, ALU and LSU to the ROM and RAM ports
`timescale 1ns/1ps

module core (
    input  logic                                 clk,
    input  logic                                 rst,
    // Instruction ROM
    output logic                                 rom_rd_en,
    output logic [core_pkg::ROM_ADDR_WIDTH-1:0]  rom_addr,
    input  core_pkg::word_t                      rom_rd_data,
    // Data RAM
    output logic                                 ram_rd_en,
    output logic                                 ram_wr_en,
    output logic [core_pkg::RAM_ADDR_WIDTH-1:0]  ram_addr,
    input  core_pkg::word_t                      ram_rd_data,
    output core_pkg::word_t                      wr_data
);
    import core_pkg::*;

    ////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////
    word_t     pc, next_pc, inst;
    gpr_addr_t rs1_addr, rs2_addr, dest_addr;
    word_t     rs1_data, rs2_data, dest_data;
    logic      dest_en;
    word_t     src1, src2, alt_data, alu_result;
    alu_op_t   alu_op;
    lsu_op_t   lsu_op;
    logic      alu_zero;

    ////////////////////////////////////////
    // Units
    ////////////////////////////////////////
    fetch fetch_inst (
        .clk, .rst, .next_pc, .pc, .inst,
        .rom_rd_en, .rom_addr, .rom_rd_data
    );

    decoder decoder_inst (
        .inst, .pc, .rs1_data, .rs2_data, .alu_zero,
        .rs1_addr, .rs2_addr, .src1, .src2, .alu_op, .lsu_op,
        .dest_addr, .alt_data, .next_pc
    );

    regfile regfile_inst (
        .clk, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .dest_en, .dest_addr, .dest_data
    );

    alu alu_inst (
        .src1, .src2, .alu_op,
        .result(alu_result),
        .zero(alu_zero)
    );

    lsu lsu_inst (
        .lsu_op, .alu_result, .alt_data, .dest_addr, .ram_rd_data,
        .dest_en, .dest_data, .ram_rd_en, .ram_wr_en, .ram_addr, .wr_data
    );

endmodule

/* sim/core_tb.sv */
// Testbench for the single-cycle RV32I core
// Runs a seeded random program from the ROM model and checks the DUT every cycle
// against an instruction-level reference model kept in the testbench
`timescale 1ns/1ps

module core_tb;
    import core_pkg::*;

    localparam int    RESET_CYCLES   = 4;
    localparam int    PROG_LEN       = 200;                   // Includes the final loop
    localparam int    TIMEOUT_CYCLES = RESET_CYCLES + 400;
    localparam int    ROM_WORDS      = 1 << ROM_ADDR_WIDTH;
    localparam int    RAM_WORDS      = 1 << RAM_ADDR_WIDTH;
    localparam word_t LOOP_PC        = ROM_BASE_ADDR + 4 * (PROG_LEN - 1);

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      rom_rd_en;
    logic [ROM_ADDR_WIDTH-1:0] rom_addr;
    word_t                     rom_rd_data;
    logic                      ram_rd_en;
    logic                      ram_wr_en;
    logic [RAM_ADDR_WIDTH-1:0] ram_addr;
    word_t                     ram_rd_data;
    word_t                     wr_data;

    word_t rom       [0:ROM_WORDS-1];
    word_t ram       [0:RAM_WORDS-1];
    word_t model_ram [0:RAM_WORDS-1]; // Reference copy of the RAM
    word_t model_regs [0:31];
    word_t model_pc;
    int    cycles = 0;

    core DUT (
        .clk, .rst, .rom_rd_en, .rom_addr, .rom_rd_data,
        .ram_rd_en, .ram_wr_en, .ram_addr, .ram_rd_data, .wr_data
    );

    ////////////////////////////////////////
    // Clock and memory models
    ////////////////////////////////////////
    always #2 clk = ~clk; // 4 ns period

    assign rom_rd_data = rom[rom_addr]; // Same-cycle read
    assign ram_rd_data = ram[ram_addr];

    always @(posedge clk) begin
        if (ram_wr_en) begin
            ram[ram_addr] <= wr_data;
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the program did not reach its final loop in %0d cycles",
                     TIMEOUT_CYCLES);
            fail_run();
        end
    end

    // No ROM or RAM strobes while in reset
    always @(negedge clk) begin
        if (rst === 1'b1) begin
            check_value("rom_rd_en", rom_rd_en, 1'b0);
            check_value("ram_rd_en", ram_rd_en, 1'b0);
            check_value("ram_wr_en", ram_wr_en, 1'b0);
        end
    end

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////
    task automatic fail_run();
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
            fail_run();
        end
    endtask

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////
    function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP};
    endfunction

    function automatic word_t enc_i(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], STORE}; // SW
    endfunction

    function automatic word_t enc_b(int off, int rs2, int rs1, logic [2:0] f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic word_t enc_u(int imm20, int rd, logic [6:0] op);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic word_t enc_j(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], JAL};
    endfunction

    ////////////////////////////////////////
    // Random program
    ////////////////////////////////////////
    function automatic int pick_rd();
        if ($urandom % 6 == 0) begin
            return 0;                      // Frequent writes to x0
        end
        return 1 + int'($urandom % 30);    // x31 stays the RAM base
    endfunction

    // Forward distance in instructions, never past the final loop
    function automatic int fwd_steps(int i);
        int room;
        room = PROG_LEN - 1 - i;
        if (room > 8) begin
            room = 8;
        end
        return 1 + int'($urandom % room);
    endfunction

    function automatic word_t fill_word(int idx);
        return 32'hc3a5_0000 ^ (idx * 32'h0001_0003); // Unique per word
    endfunction

    task automatic build_program();
        int         kind;
        int         rs1;
        int         k;
        int         imm;
        logic [2:0] f3;
        logic [6:0] f7;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = NOP_INST;
        end
        // Defined start values for x1..x30, then the RAM base in x31
        for (int r = 1; r < 31; r++) begin
            if ($urandom % 2) begin
                rom[r-1] = enc_u($urandom, r, LUI);
            end else begin
                rom[r-1] = enc_i($urandom, 0, F3_ADD_SUB, r, OP_IMM);
            end
        end
        rom[30] = enc_u(RAM_BASE_ADDR >> 12, 31, LUI);
        for (int i = 31; i < PROG_LEN - 1; i++) begin
            kind = $urandom % 12;
            f3   = $urandom % 8;
            case (kind)
                0, 1, 2: begin
                    f7 = ((f3 == F3_ADD_SUB || f3 == F3_SR) && ($urandom % 2)) ? 7'h20 : 7'h00;
                    rom[i] = enc_r(f7, $urandom % 32, $urandom % 32, f3, pick_rd());
                end
                3, 4: begin
                    imm = $urandom;
                    if (f3 == F3_SLL) imm = imm & 31;
                    if (f3 == F3_SR) imm = (imm & 31) | (($urandom % 2) ? 32'h400 : 0); // SRAI
                    rom[i] = enc_i(imm, $urandom % 32, f3, pick_rd(), OP_IMM);
                end
                5: rom[i] = enc_u($urandom, pick_rd(), ($urandom % 2) ? LUI : AUIPC);
                6, 7: begin
                    f3  = $urandom % 6;
                    f3  = (f3 >= 2) ? f3 + 3'd2 : f3; // Skip the unused funct3 codes
                    rs1 = $urandom % 32;
                    rom[i] = enc_b(4 * fwd_steps(i), ($urandom % 3 == 0) ? rs1 : $urandom % 32,
                                   rs1, f3);
                end
                8: begin
                    k = fwd_steps(i);
                    if ($urandom % 2) begin
                        rom[i] = enc_j(4 * k, pick_rd());
                    end else begin
                        // Absolute target off x0, bit 0 sometimes set
                        imm = int'(ROM_BASE_ADDR) + 4 * (i + k) + int'($urandom % 2);
                        rom[i] = enc_i(imm, 0, 3'b000, pick_rd(), JALR);
                    end
                end
                9:  rom[i] = enc_i(4 * ($urandom % 32), 31, 3'b010, pick_rd(), LOAD);
                default: begin
                    rom[i] = enc_s(4 * ($urandom % 32), ($urandom % 6 == 0) ? 0 : $urandom % 32,
                                   31);
                end
            endcase
        end
        rom[PROG_LEN-1] = enc_j(0, 0); // Jump to self
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic logic in_ram(word_t addr);
        return (addr - RAM_BASE_ADDR) < (RAM_WORDS * 4);
    endfunction

    function automatic int ram_index(word_t addr);
        return int'((addr - RAM_BASE_ADDR) >> 2);
    endfunction

    // Checks the current cycle, then retires one instruction
    task automatic step_model();
        word_t      inst;
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      addr;
        word_t      next_pc;
        word_t      imm_i;
        logic [2:0] f3;
        logic       wr_rd;
        logic       taken;
        logic       is_load;
        logic       is_store;
        int         rom_idx;
        rom_idx  = int'((model_pc - ROM_BASE_ADDR) >> 2);
        inst     = rom[rom_idx];
        a        = model_regs[inst[19:15]];
        b        = model_regs[inst[24:20]];
        f3       = inst[14:12];
        imm_i    = {{20{inst[31]}}, inst[31:20]};
        next_pc  = model_pc + 4;
        res      = '0;
        addr     = '0;
        wr_rd    = 1'b0;
        taken    = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (inst[6:0])
            OP, OP_IMM: begin
                if (inst[6:0] == OP_IMM) b = imm_i;
                case (f3)
                    F3_ADD_SUB: res = (inst[30] && inst[5]) ? a - b : a + b; // SUB only in OP
                    F3_SLL:     res = a << b[4:0];
                    F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    F3_SLTU:    res = (a < b) ? 32'd1 : 32'd0;
                    F3_XOR:     res = a ^ b;
                    F3_SR:      res = inst[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    F3_OR:      res = a | b;
                    default:    res = a & b;
                endcase
                wr_rd = 1'b1;
            end
            LUI: begin
                res   = {inst[31:12], 12'b0};
                wr_rd = 1'b1;
            end
            AUIPC: begin
                res   = model_pc + {inst[31:12], 12'b0};
                wr_rd = 1'b1;
            end
            BRANCH: begin
                case (f3)
                    F3_BEQ:  taken = (a == b);
                    F3_BNE:  taken = (a != b);
                    F3_BLT:  taken = ($signed(a) < $signed(b));
                    F3_BGE:  taken = ($signed(a) >= $signed(b));
                    F3_BLTU: taken = (a < b);
                    F3_BGEU: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = model_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                          inst[11:8], 1'b0};
                end
            end
            JAL: begin
                res     = model_pc + 4;
                wr_rd   = 1'b1;
                next_pc = model_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                      inst[30:21], 1'b0};
            end
            JALR: begin
                res     = model_pc + 4;
                wr_rd   = 1'b1;
                next_pc = (a + imm_i) & ~32'd1;
            end
            LOAD: begin
                addr    = a + imm_i;
                is_load = in_ram(addr);
                res     = is_load ? model_ram[ram_index(addr)] : '0; // Zero outside RAM
                wr_rd   = 1'b1;
            end
            STORE: begin
                addr     = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                is_store = in_ram(addr);
            end
            default: begin
            end
        endcase
        check_value("rom_addr", rom_addr, rom_idx);
        check_value("rom_rd_en", rom_rd_en, 1'b1);
        check_value("ram_rd_en", ram_rd_en, is_load);
        check_value("ram_wr_en", ram_wr_en, is_store);
        if (is_load || is_store) check_value("ram_addr", ram_addr, ram_index(addr));
        if (is_store) begin
            check_value("wr_data", wr_data, b);
            model_ram[ram_index(addr)] = b;
        end
        if (wr_rd && inst[11:7] != 5'd0) model_regs[inst[11:7]] = res; // x0 stays zero
        model_pc = next_pc;
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        rst = 1'b1;
        void'($urandom(32'h9d59_dabf));
        build_program();
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i]       = fill_word(i);
            model_ram[i] = fill_word(i);
        end
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        model_pc = RESET_ADDR;

        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;

        @(negedge clk);
        check_value("rom_addr", rom_addr, (RESET_ADDR - ROM_BASE_ADDR) >> 2); // First fetch
        while (model_pc != LOOP_PC) begin
            step_model();
            @(negedge clk);
        end
        step_model(); // The loop instruction itself

        // Every store has landed by now
        for (int i = 0; i < RAM_WORDS; i++) begin
            check_value($sformatf("ram[%0d]", i), ram[i], model_ram[i]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* compile.f */
rtl/core_pkg.sv
rtl/fetch.sv
rtl/regfile.sv
rtl/decoder.sv
rtl/alu.sv
rtl/lsu.sv
rtl/core.sv
sim/core_tb.sv
